/* logic/cpu_pkg.sv */
// ======================================
// cpu_pkg
// shared types for the execute slice:
// ROB tags, ALU ops, issue and CDB packets
// ======================================

`default_nettype none

package cpu_pkg;

	// datapath width
	localparam int xlen = 32;

	// ROB has 8 entries
	localparam int rob_bits = 3;

	typedef logic [rob_bits-1:0] rob_tag_t;

	typedef enum logic {
		op_add = 1'b0,
		op_sub = 1'b1
	} alu_op_t;

	// any branch forces a subtract in the unit
	typedef enum logic [1:0] {
		br_none = 2'b00,
		br_bne  = 2'b01,
		br_beq  = 2'b10,
		br_blt  = 2'b11
	} branch_type_t;

	// one issued micro-op, operands already read
	typedef struct packed {
		rob_tag_t          rob_tag;
		alu_op_t           alu_op;
		branch_type_t      branch_type;
		logic [xlen-1:0]   rs1;
		logic [xlen-1:0]   rs2;
	} issue_packet_t;

	// CDB broadcast word, same layout as the memory units use
	typedef struct packed {
		rob_tag_t          dest_rob_entry;
		logic [xlen-1:0]   result;
		logic              branch_result;  // taken flag
		logic              from_memory;    // always 0 here
	} cdb_packet_t;

endpackage

`default_nettype wire

/* logic/adder_32bit.sv */
// ======================================
// adder_32bit
// ripple-carry add/sub with zero,
// negative and overflow flags
// ======================================

`timescale 1ns/1ps
`default_nettype none

module adder_32bit (
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	input  logic                     sub,
	output logic [cpu_pkg::xlen-1:0] s,
	output logic                     zero,
	output logic                     negative,
	output logic                     overflow
);
	import cpu_pkg::*;

	localparam int groups = xlen / 4;

	logic [xlen:0] c;           // carry chain, c[0] is the carry-in
	logic [groups-1:0] nib_or;

	assign c[0] = sub;  // +1 completes two's complement of b

	genvar i;
	generate
		for (i = 0; i < xlen; i++) begin : g_cell
			logic bx;
			logic p;

			assign bx = b[i] ^ sub;
			assign p = a[i] ^ bx;
			assign s[i] = p ^ c[i];
			assign c[i+1] = (a[i] & bx) | (p & c[i]);
		end
	endgenerate

	// two-level OR tree, nibbles first
	genvar g;
	generate
		for (g = 0; g < groups; g++) begin : g_nib
			assign nib_or[g] = |s[4*g +: 4];
		end
	endgenerate

	assign zero = ~|nib_or;
	assign negative = s[xlen-1];
	assign overflow = c[xlen] ^ c[xlen-1];  // carry into vs out of sign bit

endmodule

`default_nettype wire

/* logic/add_sub_unit.sv */
// ======================================
// add_sub_unit
// add/sub FU, resolves bne/beq/blt and
// holds one CDB packet until yumi
// ======================================

`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid_in,
	input  cpu_pkg::issue_packet_t op_in,
	output logic                   ready,
	input  logic                   yumi,
	output logic                   valid_out,
	output cpu_pkg::cdb_packet_t   out
);
	import cpu_pkg::*;

	logic [xlen-1:0] sum;
	logic zero;
	logic negative;
	logic overflow;
	logic sub;
	logic taken;
	logic accept;
	cdb_packet_t held;

	// branches compare by subtracting
	assign sub = (op_in.alu_op == op_sub) || (op_in.branch_type != br_none);

	adder_32bit i_adder (
		.a        (op_in.rs1),
		.b        (op_in.rs2),
		.sub      (sub),
		.s        (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow)
	);

	always_comb begin
		case (op_in.branch_type)
			br_bne:  taken = ~zero;
			br_beq:  taken = zero;
			br_blt:  taken = negative ^ overflow;  // signed less-than
			default: taken = 1'b0;
		endcase
	end

	// one op in flight, free again after yumi
	assign ready = ~valid_out;
	assign accept = valid_in & ready;

	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= 1'b0;
		else if (accept)
			valid_out <= 1'b1;
		else if (yumi)
			valid_out <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			held.dest_rob_entry <= op_in.rob_tag;
			held.result <= sum;
			held.branch_result <= taken;
			held.from_memory <= 1'b0;
		end
	end

	assign out = held;

	// CDB may only take a packet that is on offer
	a_yumi_valid: assert property (@(posedge clk) disable iff (reset)
		yumi |-> valid_out);

	// a stalled producer keeps its op steady until taken
	a_op_held: assert property (@(posedge clk) disable iff (reset)
		valid_in && !ready |=> valid_in && $stable(op_in));

endmodule

`default_nettype wire

/* logic/issue_queue.sv */
// ======================================
// issue_queue
// in-order FIFO of issued micro-ops,
// ready/valid on both sides
// ======================================

`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
	parameter int DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	input  cpu_pkg::issue_packet_t in_packet,
	output logic                   in_ready,
	output logic                   out_valid,
	output cpu_pkg::issue_packet_t out_packet,
	input  logic                   out_ready
);
	import cpu_pkg::*;

	localparam int ptr_bits = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cnt_bits = $clog2(DEPTH + 1);

	issue_packet_t mem [DEPTH];
	logic [ptr_bits-1:0] head;
	logic [ptr_bits-1:0] tail;
	logic [cnt_bits-1:0] count;
	logic full;
	logic push;
	logic pop;

	function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
		if (p == ptr_bits'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = (count == cnt_bits'(DEPTH));
	assign in_ready = !full || out_ready;  // full, but the head leaves this cycle
	assign push = in_valid && in_ready;

	assign out_valid = (count != '0);
	assign out_packet = mem[head];
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= next_ptr(tail);
			if (pop)
				head <= next_ptr(head);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[tail] <= in_packet;
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= cnt_bits'(DEPTH));

	// head meets tail only when empty or full
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> (head != tail) || full);

endmodule

`default_nettype wire

/* logic/execute_cluster.sv */
// ======================================
// execute_cluster
// issue queue feeding the add/sub unit,
// results go out on the CDB
// ======================================

`timescale 1ns/1ps
`default_nettype none

module execute_cluster #(
	parameter int DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  cpu_pkg::issue_packet_t issue_packet,
	output logic                   issue_ready,
	output logic                   cdb_valid,
	output cpu_pkg::cdb_packet_t   cdb_packet,
	input  logic                   yumi
);
	import cpu_pkg::*;

	logic q_valid;
	issue_packet_t q_packet;
	logic unit_ready;

	issue_queue #(
		.DEPTH (DEPTH)
	) i_issue_queue (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (issue_valid),
		.in_packet  (issue_packet),
		.in_ready   (issue_ready),
		.out_valid  (q_valid),
		.out_packet (q_packet),
		.out_ready  (unit_ready)
	);

	add_sub_unit i_add_sub_unit (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (q_valid),
		.op_in     (q_packet),
		.ready     (unit_ready),
		.yumi      (yumi),
		.valid_out (cdb_valid),
		.out       (cdb_packet)
	);

endmodule

`default_nettype wire

/* testbench/tb_vectors.svh */
// ========================================
// stimulus table for the execute slice
// one micro-op per row, ROB tag is row % 8
// ========================================

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: alu op, branch type, rs1, rs2, expected result, expected taken
typedef struct packed {
	alu_op_t      op;
	branch_type_t br;
	logic [31:0]  rs1;
	logic [31:0]  rs2;
	logic [31:0]  result;
	logic         taken;
} vector_t;

localparam int n_rows = 26;

localparam vector_t vectors [n_rows] = '{
	'{op_add, br_none, 32'h0000_0005, 32'h0000_0003, 32'h0000_0008, 1'b0},
	'{op_add, br_none, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0},  // carry out dropped
	'{op_add, br_none, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0},
	'{op_add, br_none, 32'h1234_5678, 32'h8765_4321, 32'h9999_9999, 1'b0},
	'{op_sub, br_none, 32'h0000_0005, 32'h0000_0003, 32'h0000_0002, 1'b0},
	'{op_sub, br_none, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 1'b0},  // below zero
	'{op_sub, br_none, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0},
	'{op_sub, br_none, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b0},
	'{op_sub, br_beq,  32'h0000_002a, 32'h0000_002a, 32'h0000_0000, 1'b1},
	'{op_sub, br_beq,  32'h0000_002a, 32'h0000_002b, 32'hffff_ffff, 1'b0},
	'{op_add, br_bne,  32'hdead_beef, 32'hdead_beef, 32'h0000_0000, 1'b0},  // branch forces sub
	'{op_sub, br_bne,  32'h0000_0010, 32'h0000_0001, 32'h0000_000f, 1'b1},
	'{op_sub, br_blt,  32'h0000_0001, 32'h0000_0002, 32'hffff_ffff, 1'b1},
	'{op_sub, br_blt,  32'h0000_0002, 32'h0000_0001, 32'h0000_0001, 1'b0},
	'{op_sub, br_blt,  32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff, 1'b1},  // -1 < 0
	'{op_sub, br_blt,  32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 1'b0},
	'{op_sub, br_blt,  32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b1},  // overflows
	'{op_sub, br_blt,  32'h7fff_ffff, 32'hffff_ffff, 32'h8000_0000, 1'b0},  // overflows
	'{op_sub, br_blt,  32'h0000_0007, 32'h0000_0007, 32'h0000_0000, 1'b0},
	'{op_add, br_none, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b0},
	'{op_sub, br_beq,  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
	'{op_add, br_bne,  32'h0000_0001, 32'h0000_0002, 32'hffff_ffff, 1'b1},
	'{op_sub, br_none, 32'ha5a5_a5a5, 32'h5a5a_5a5a, 32'h4b4b_4b4b, 1'b0},
	'{op_add, br_none, 32'h0f0f_0f0f, 32'hf0f0_f0f1, 32'h0000_0000, 1'b0},
	'{op_sub, br_blt,  32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b1},  // min < max
	'{op_sub, br_blt,  32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 1'b0}
};

`endif

/* testbench/tb_execute_cluster.sv */
// ========================================
// tb_execute_cluster
// table-driven testbench for the execute
// slice with random CDB back-pressure
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_execute_cluster;
	import cpu_pkg::*;

	`include "tb_vectors.svh"

	localparam int depth = 4;
	localparam int wait_limit = 200;
	localparam int stall_cycles = 20;

	logic clk;
	logic reset;
	logic issue_valid;
	issue_packet_t issue_packet;
	logic issue_ready;
	logic cdb_valid;
	cdb_packet_t cdb_packet;
	logic yumi;

	cdb_packet_t exp_q [$];  // scoreboard, issue order
	logic [31:0] lcg_state = 32'd70454;
	logic hold_yumi;

	execute_cluster #(
		.DEPTH (depth)
	) i_execute_cluster (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue_packet (issue_packet),
		.issue_ready  (issue_ready),
		.cdb_valid    (cdb_valid),
		.cdb_packet   (cdb_packet),
		.yumi         (yumi)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;  // low bits repeat quickly
	endfunction

	task automatic stop_run(input string why);
		$display("ERROR: %s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("FAIL %s: got %h, expected %h", name, got, want);
			$display("Some tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic issue_packet_t row_packet(input int idx);
		issue_packet_t p;
		p.rob_tag = rob_tag_t'(idx % 8);
		p.alu_op = vectors[idx].op;
		p.branch_type = vectors[idx].br;
		p.rs1 = vectors[idx].rs1;
		p.rs2 = vectors[idx].rs2;
		return p;
	endfunction

	function automatic cdb_packet_t expected_result(input int idx);
		cdb_packet_t p;
		p.dest_rob_entry = rob_tag_t'(idx % 8);
		p.result = vectors[idx].result;
		p.branch_result = vectors[idx].taken;
		p.from_memory = 1'b0;
		return p;
	endfunction

	task automatic drive_rows();
		int i;
		int waited;
		logic sent;
		for (i = 0; i < n_rows; i++) begin
			@(posedge clk);
			if (i % 5 == 3) begin  // idle bubble now and then
				issue_valid <= 1'b0;
				@(posedge clk);
			end
			issue_valid <= 1'b1;
			issue_packet <= row_packet(i);
			sent = 1'b0;
			waited = 0;
			while (!sent) begin
				@(negedge clk);
				if (issue_ready) begin
					exp_q.push_back(expected_result(i));  // transfers on next edge
					sent = 1'b1;
				end else begin
					waited++;
					if (waited > wait_limit)
						stop_run("issue_ready stayed low and the queue never drained");
					@(posedge clk);
				end
			end
		end
		@(posedge clk);
		issue_valid <= 1'b0;
	endtask

	task automatic collect_results(input int n);
		int got;
		int idle;
		logic take;
		logic seen;
		cdb_packet_t want;
		got = 0;
		idle = 0;
		while (got < n) begin
			@(negedge clk);
			seen = cdb_valid;
			take = cdb_valid && yumi;
			if (take) begin
				if (exp_q.size() == 0)
					stop_run("a CDB result arrived with no op outstanding");
				want = exp_q.pop_front();
				compare_value("dest_rob_entry", 32'(cdb_packet.dest_rob_entry),
					32'(want.dest_rob_entry));
				compare_value("result", cdb_packet.result, want.result);
				compare_value("branch_result", 32'(cdb_packet.branch_result),
					32'(want.branch_result));
				compare_value("from_memory", 32'(cdb_packet.from_memory), 32'd0);
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > wait_limit)
					stop_run("no result was taken from the CDB in time");
			end
			@(posedge clk);
			// valid stays up until yumi, so this never offers yumi without valid
			if (!take && seen && !hold_yumi && (next_random() % 3 != 0))
				yumi <= 1'b1;
			else
				yumi <= 1'b0;
		end
	endtask

	task automatic wait_for_stall();
		int waited;
		waited = 0;
		@(negedge clk);
		while (issue_ready) begin
			waited++;
			if (waited > wait_limit)
				stop_run("issue_ready never fell while yumi was held off");
			@(negedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_packet = '0;
		yumi = 1'b0;
		hold_yumi = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		compare_value("issue_ready", 32'(issue_ready), 32'd1);
		compare_value("cdb_valid", 32'(cdb_valid), 32'd0);
		compare_value("q_valid", 32'(i_execute_cluster.q_valid), 32'd0);

		// random yumi
		fork
			drive_rows();
			collect_results(n_rows);
		join

		// yumi held off until the queue backs up, then drained
		hold_yumi = 1'b1;
		fork
			drive_rows();
			collect_results(n_rows);
			begin
				wait_for_stall();
				compare_value("ops in flight", 32'(exp_q.size()), 32'(depth + 1));
				repeat (stall_cycles) begin
					@(negedge clk);
					compare_value("issue_ready", 32'(issue_ready), 32'd0);
				end
				compare_value("ops in flight", 32'(exp_q.size()), 32'(depth + 1));
				hold_yumi = 1'b0;
			end
		join

		@(negedge clk);
		compare_value("issue_ready", 32'(issue_ready), 32'd1);
		compare_value("cdb_valid", 32'(cdb_valid), 32'd0);
		if (exp_q.size() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "issued ops never reached the CDB");
		end
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+testbench
logic/cpu_pkg.sv
logic/adder_32bit.sv
logic/add_sub_unit.sv
logic/issue_queue.sv
logic/execute_cluster.sv
testbench/tb_execute_cluster.sv

/* Makefile */
# Verilator build and run for the execute slice testbench

VERILATOR ?= verilator
TOP       ?= tb_execute_cluster
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  TOP=$(TOP)"
	@echo "  FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR)"
	@echo "  VFLAGS=$(VFLAGS)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
